//--- logic/wb_pkg.sv
package wb_pkg;

    // ------------------------------------------------------------------------
    // data widths with a meaning of their own
    // ------------------------------------------------------------------------

    // register or memory data word
    typedef logic [31:0] word_t;

    // one byte of a word
    typedef logic [7:0] byte_t;

    // register write enable, one bit per byte lane
    typedef logic [3:0] byte_en_t;

    // register number
    typedef logic [4:0] reg_addr_t;

    // index of a byte inside a word
    typedef logic [1:0] lane_sel_t;

    // byte lanes in a register word
    localparam int NUM_LANES = 4;

    // ------------------------------------------------------------------------
    // writeback op and lane control codes
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        WB_NONE,
        WB_ALU,
        WB_LB,
        WB_LBU,
        WB_LH,
        WB_LHU,
        WB_LW,
        WB_LWL,
        WB_LWR
    } wb_op_t;

    // what a lane puts on its byte
    typedef enum logic [1:0] {
        LANE_MEM,
        LANE_SIGN,
        LANE_ZERO,
        LANE_KEEP
    } lane_mode_t;

endpackage

//--- logic/wb_byte_lane.sv
`timescale 1ns/1ps

module wb_byte_lane (
    input  wb_pkg::word_t      lane_word,
    input  wb_pkg::lane_sel_t  lane_sel,
    input  wb_pkg::lane_mode_t lane_mode,
    input  logic               fill_sign,
    output wb_pkg::byte_t      lane_byte,
    output logic               lane_we
);

    wb_pkg::byte_t mem_byte;

    // selected byte of the incoming word
    assign mem_byte = lane_word[{lane_sel, 3'b000} +: 8];

    always_comb begin
        case (lane_mode)
            wb_pkg::LANE_MEM: begin
                lane_byte = mem_byte;
            end
            wb_pkg::LANE_SIGN: begin
                lane_byte = {8{fill_sign}};
            end
            // zero fill, and a kept lane drives zero as well
            default: begin
                lane_byte = 8'h00;
            end
        endcase
    end

    // kept lane leaves the old register byte in place
    assign lane_we = (lane_mode != wb_pkg::LANE_KEEP);

endmodule

//--- logic/wb_stage_reg.sv
`timescale 1ns/1ps

module wb_stage_reg (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       mem_valid,
    input  wb_pkg::word_t                              mem_pc,
    input  wb_pkg::wb_op_t                             mem_op,
    input  wb_pkg::reg_addr_t                          mem_wnum,
    input  wb_pkg::lane_sel_t                          mem_addr_lo,
    input  wb_pkg::word_t                              mem_load_data,
    input  wb_pkg::word_t                              mem_alu_data,
    output logic                                       wb_valid,
    output wb_pkg::word_t                              wb_pc,
    output wb_pkg::reg_addr_t                          wb_wnum,
    output wb_pkg::word_t                              lane_word,
    output wb_pkg::lane_sel_t  [wb_pkg::NUM_LANES-1:0] lane_sel,
    output wb_pkg::lane_mode_t [wb_pkg::NUM_LANES-1:0] lane_mode,
    output logic                                       fill_sign
);

    wb_pkg::wb_op_t     op_r;
    wb_pkg::lane_sel_t  addr_r;
    wb_pkg::word_t      data_r;
    wb_pkg::lane_sel_t  sign_idx;
    wb_pkg::lane_mode_t fill_mode;
    logic [2:0]         lane_sum;

    // ------------------------------------------------------------------------
    // mem to wb register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            op_r     <= wb_pkg::WB_NONE;
        end else begin
            wb_valid <= mem_valid;
            if (mem_valid) begin
                op_r <= mem_op;
            end
        end
    end

    // alu result rides the same data path as a loaded word
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_pc   <= mem_pc;
            wb_wnum <= mem_wnum;
            addr_r  <= mem_addr_lo;
            data_r  <= (mem_op == wb_pkg::WB_ALU) ? mem_alu_data : mem_load_data;
        end
    end

    assign lane_word = data_r;

    // ------------------------------------------------------------------------
    // per-lane decode
    // ------------------------------------------------------------------------

    // sign bit sits at the top of byte a, or of byte a+1 for halfwords
    assign sign_idx  = (op_r == wb_pkg::WB_LH || op_r == wb_pkg::WB_LHU) ?
                       {addr_r[1], 1'b1} : addr_r;
    assign fill_sign = data_r[{sign_idx, 3'b111}];
    assign fill_mode = (op_r == wb_pkg::WB_LB || op_r == wb_pkg::WB_LH) ?
                       wb_pkg::LANE_SIGN : wb_pkg::LANE_ZERO;

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_LANES; i++) begin
            // lane index plus address, picks the byte for lwl and lwr
            lane_sum     = 3'(i) + {1'b0, addr_r};
            lane_sel[i]  = wb_pkg::lane_sel_t'(i);
            lane_mode[i] = wb_pkg::LANE_KEEP;
            case (op_r)
                wb_pkg::WB_ALU, wb_pkg::WB_LW: begin
                    lane_mode[i] = wb_pkg::LANE_MEM;
                end
                wb_pkg::WB_LB, wb_pkg::WB_LBU: begin
                    if (i == 0) begin
                        lane_sel[i]  = addr_r;
                        lane_mode[i] = wb_pkg::LANE_MEM;
                    end else begin
                        lane_mode[i] = fill_mode;
                    end
                end
                wb_pkg::WB_LH, wb_pkg::WB_LHU: begin
                    if (i < 2) begin
                        lane_sel[i]  = {addr_r[1], 1'b0} | wb_pkg::lane_sel_t'(i);
                        lane_mode[i] = wb_pkg::LANE_MEM;
                    end else begin
                        lane_mode[i] = fill_mode;
                    end
                end
                // upper lanes take the low bytes, i + a - 3
                wb_pkg::WB_LWL: begin
                    if (lane_sum >= 3'd3) begin
                        lane_sel[i]  = wb_pkg::lane_sel_t'(lane_sum + 3'd1);
                        lane_mode[i] = wb_pkg::LANE_MEM;
                    end
                end
                // lower lanes take the high bytes, i + a
                wb_pkg::WB_LWR: begin
                    if (lane_sum <= 3'd3) begin
                        lane_sel[i]  = lane_sum[1:0];
                        lane_mode[i] = wb_pkg::LANE_MEM;
                    end
                end
                default: begin
                    lane_mode[i] = wb_pkg::LANE_KEEP;
                end
            endcase
        end
    end

endmodule

//--- logic/wb_result_merge.sv
`timescale 1ns/1ps

module wb_result_merge (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wb_valid,
    input  wb_pkg::word_t                         wb_pc,
    input  wb_pkg::reg_addr_t                     wb_wnum,
    input  wb_pkg::byte_t [wb_pkg::NUM_LANES-1:0] lane_bytes,
    input  wb_pkg::byte_en_t                      lane_we,
    output wb_pkg::byte_en_t                      rf_we,
    output wb_pkg::reg_addr_t                     rf_waddr,
    output wb_pkg::word_t                         rf_wdata,
    output wb_pkg::word_t                         debug_wb_pc,
    output wb_pkg::byte_en_t                      debug_wb_rf_wen,
    output wb_pkg::reg_addr_t                     debug_wb_rf_wnum,
    output wb_pkg::word_t                         debug_wb_rf_wdata
);

    logic wr_allowed;

    // ------------------------------------------------------------------------
    // register file write port
    // ------------------------------------------------------------------------

    // nothing is written for a bubble or for $0
    assign wr_allowed = wb_valid && (wb_wnum != 5'd0);
    assign rf_we      = wr_allowed ? lane_we : 4'b0000;
    assign rf_waddr   = wb_wnum;

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_LANES; i++) begin
            rf_wdata[8*i +: 8] = lane_bytes[i];
        end
    end

    // ------------------------------------------------------------------------
    // debug trace
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_wb_pc       <= 32'h0000_0000;
            debug_wb_rf_wen   <= 4'b0000;
            debug_wb_rf_wnum  <= 5'd0;
            debug_wb_rf_wdata <= 32'h0000_0000;
        end else begin
            debug_wb_rf_wen <= rf_we;
            // trace fields hold through bubbles
            if (wb_valid) begin
                debug_wb_pc       <= wb_pc;
                debug_wb_rf_wnum  <= wb_wnum;
                debug_wb_rf_wdata <= rf_wdata;
            end
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::byte_en_t  we,
    input  wb_pkg::reg_addr_t waddr,
    input  wb_pkg::word_t     wdata,
    input  wb_pkg::reg_addr_t rs_addr,
    input  wb_pkg::reg_addr_t rt_addr,
    output wb_pkg::word_t     rs_data,
    output wb_pkg::word_t     rt_data
);

    wb_pkg::word_t regs [32];

    // ------------------------------------------------------------------------
    // byte-enabled write
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= 32'h0000_0000;
            end
        end else begin
            for (int b = 0; b < wb_pkg::NUM_LANES; b++) begin
                if (we[b]) begin
                    regs[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------------

    // $0 is hard-wired to zero
    assign rs_data = (rs_addr == 5'd0) ? 32'h0000_0000 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0000_0000 : regs[rt_addr];

endmodule

//--- logic/wb_top.sv
`timescale 1ns/1ps

module wb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_valid,
    input  wb_pkg::word_t     mem_pc,
    input  wb_pkg::wb_op_t    mem_op,
    input  wb_pkg::reg_addr_t mem_wnum,
    input  wb_pkg::lane_sel_t mem_addr_lo,
    input  wb_pkg::word_t     mem_load_data,
    input  wb_pkg::word_t     mem_alu_data,
    input  wb_pkg::reg_addr_t rs_addr,
    input  wb_pkg::reg_addr_t rt_addr,
    output wb_pkg::word_t     rs_data,
    output wb_pkg::word_t     rt_data,
    output wb_pkg::word_t     debug_wb_pc,
    output wb_pkg::byte_en_t  debug_wb_rf_wen,
    output wb_pkg::reg_addr_t debug_wb_rf_wnum,
    output wb_pkg::word_t     debug_wb_rf_wdata
);

    // stage register outputs
    logic                                       wb_valid;
    wb_pkg::word_t                              wb_pc;
    wb_pkg::reg_addr_t                          wb_wnum;
    wb_pkg::word_t                              lane_word;
    wb_pkg::lane_sel_t  [wb_pkg::NUM_LANES-1:0] lane_sel;
    wb_pkg::lane_mode_t [wb_pkg::NUM_LANES-1:0] lane_mode;
    logic                                       fill_sign;

    // lane outputs
    wb_pkg::byte_t [wb_pkg::NUM_LANES-1:0]      lane_bytes;
    wb_pkg::byte_en_t                           lane_we;

    // register file write port
    wb_pkg::byte_en_t                           rf_we;
    wb_pkg::reg_addr_t                          rf_waddr;
    wb_pkg::word_t                              rf_wdata;

    wb_stage_reg wb_stage_reg_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_valid     (mem_valid),
        .mem_pc        (mem_pc),
        .mem_op        (mem_op),
        .mem_wnum      (mem_wnum),
        .mem_addr_lo   (mem_addr_lo),
        .mem_load_data (mem_load_data),
        .mem_alu_data  (mem_alu_data),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_wnum       (wb_wnum),
        .lane_word     (lane_word),
        .lane_sel      (lane_sel),
        .lane_mode     (lane_mode),
        .fill_sign     (fill_sign)
    );

    // ------------------------------------------------------------------------
    // one aligner per register byte
    // ------------------------------------------------------------------------

    for (genvar g = 0; g < wb_pkg::NUM_LANES; g++) begin : gen_lane
        wb_byte_lane wb_byte_lane_inst (
            .lane_word (lane_word),
            .lane_sel  (lane_sel[g]),
            .lane_mode (lane_mode[g]),
            .fill_sign (fill_sign),
            .lane_byte (lane_bytes[g]),
            .lane_we   (lane_we[g])
        );
    end

    wb_result_merge wb_result_merge_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .wb_valid          (wb_valid),
        .wb_pc             (wb_pc),
        .wb_wnum           (wb_wnum),
        .lane_bytes        (lane_bytes),
        .lane_we           (lane_we),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

endmodule

//--- bench/wb_clock_gen.sv
`timescale 1ns/1ps

module wb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- bench/wb_tb.sv
`timescale 1ns/1ps

module wb_tb;

    typedef struct {
        string             name;
        logic              valid;
        wb_pkg::word_t     pc;
        wb_pkg::wb_op_t    op;
        wb_pkg::reg_addr_t wnum;
        wb_pkg::lane_sel_t addr_lo;
        wb_pkg::word_t     load_data;
        wb_pkg::word_t     alu_data;
        wb_pkg::byte_en_t  exp_wen;
        wb_pkg::word_t     exp_wdata;
        wb_pkg::word_t     exp_pc;
        wb_pkg::word_t     exp_reg;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              mem_valid;
    wb_pkg::word_t     mem_pc;
    wb_pkg::wb_op_t    mem_op;
    wb_pkg::reg_addr_t mem_wnum;
    wb_pkg::lane_sel_t mem_addr_lo;
    wb_pkg::word_t     mem_load_data;
    wb_pkg::word_t     mem_alu_data;
    wb_pkg::reg_addr_t rs_addr;
    wb_pkg::reg_addr_t rt_addr;
    wb_pkg::word_t     rs_data;
    wb_pkg::word_t     rt_data;
    wb_pkg::word_t     debug_wb_pc;
    wb_pkg::byte_en_t  debug_wb_rf_wen;
    wb_pkg::reg_addr_t debug_wb_rf_wnum;
    wb_pkg::word_t     debug_wb_rf_wdata;

    row_t          rows [$];
    wb_pkg::word_t model_regs [32];
    wb_pkg::word_t last_pc;
    int            errors;
    integer        seed;
    bit            table_ready;

    wb_clock_gen wb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wb_top wb_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_op            (mem_op),
        .mem_wnum          (mem_wnum),
        .mem_addr_lo       (mem_addr_lo),
        .mem_load_data     (mem_load_data),
        .mem_alu_data      (mem_alu_data),
        .rs_addr           (rs_addr),
        .rt_addr           (rt_addr),
        .rs_data           (rs_data),
        .rt_data           (rt_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input wb_pkg::word_t exp,
                              input wb_pkg::word_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte_en(input string name, input wb_pkg::byte_en_t exp,
                                 input wb_pkg::byte_en_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_reg_addr(input string name, input wb_pkg::reg_addr_t exp,
                                  input wb_pkg::reg_addr_t act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // new register value from the little-endian load rules with old bytes kept
    task automatic merge_result(input wb_pkg::wb_op_t op, input int a, input wb_pkg::word_t ld,
                                input wb_pkg::word_t alu, input wb_pkg::word_t old,
                                output wb_pkg::byte_en_t en, output wb_pkg::word_t data);
        wb_pkg::byte_t fill;
        en   = 4'b1111;
        data = old;
        fill = 8'h00;
        case (op)
            wb_pkg::WB_ALU: data = alu;
            wb_pkg::WB_LW:  data = ld;
            wb_pkg::WB_LB, wb_pkg::WB_LBU: begin
                if (op == wb_pkg::WB_LB && ld[8*a+7]) fill = 8'hff;
                data = {fill, fill, fill, ld[8*a +: 8]};
            end
            wb_pkg::WB_LH, wb_pkg::WB_LHU: begin
                if (op == wb_pkg::WB_LH && ld[8*a+15]) fill = 8'hff;
                data = {fill, fill, ld[8*a +: 16]};
            end
            wb_pkg::WB_LWL: begin
                en = 4'b0000;
                for (int k = 0; k <= a; k++) begin
                    data[8*(3-a+k) +: 8] = ld[8*k +: 8];
                    en[3-a+k]            = 1'b1;
                end
            end
            wb_pkg::WB_LWR: begin
                en = 4'b0000;
                for (int k = 0; k <= 3 - a; k++) begin
                    data[8*k +: 8] = ld[8*(a+k) +: 8];
                    en[k]          = 1'b1;
                end
            end
            default: en = 4'b0000;
        endcase
    endtask

    function automatic wb_pkg::word_t byte_mask(input wb_pkg::byte_en_t en);
        wb_pkg::word_t m;
        for (int b = 0; b < wb_pkg::NUM_LANES; b++) begin
            m[8*b +: 8] = {8{en[b]}};
        end
        return m;
    endfunction

    // ------------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------------

    task automatic add_row(input string name, input logic valid, input wb_pkg::wb_op_t op,
                           input wb_pkg::reg_addr_t wnum, input wb_pkg::lane_sel_t a,
                           input wb_pkg::word_t ld, input wb_pkg::word_t alu);
        row_t             r;
        wb_pkg::byte_en_t en;
        wb_pkg::word_t    data;
        r.name      = name;
        r.valid     = valid;
        r.pc        = 32'hbfc0_0000 + 32'(rows.size() * 4);
        r.op        = op;
        r.wnum      = wnum;
        r.addr_lo   = a;
        r.load_data = ld;
        r.alu_data  = alu;
        merge_result(op, int'(a), ld, alu, model_regs[wnum], en, data);
        if (!valid || wnum == 5'd0) en = 4'b0000;
        if (valid) last_pc = r.pc;
        if (en != 4'b0000) model_regs[wnum] = data;
        r.exp_wen   = en;
        r.exp_wdata = data;
        r.exp_pc    = last_pc;
        r.exp_reg   = model_regs[wnum];
        rows.push_back(r);
    endtask

    task automatic build_table();
        wb_pkg::word_t     ld;
        wb_pkg::lane_sel_t a;
        wb_pkg::wb_op_t    op;
        add_row("alu r1", 1'b1, wb_pkg::WB_ALU, 5'd1, 2'd0, 32'hdead_beef, 32'h1234_5678);
        add_row("alu r2", 1'b1, wb_pkg::WB_ALU, 5'd2, 2'd3, 32'h0, 32'h8765_4321);
        add_row("lw r3", 1'b1, wb_pkg::WB_LW, 5'd3, 2'd0, 32'h89ab_cdef, 32'hffff_ffff);
        // byte and halfword loads with top bits set and clear in both words
        for (int w = 0; w < 2; w++) begin
            ld = (w == 0) ? 32'h807f_c325 : 32'h7f80_3cd2;
            for (int i = 0; i < 4; i++) begin
                add_row($sformatf("lb a=%0d w=%0d", i, w), 1'b1, wb_pkg::WB_LB, 5'(4 + i),
                        2'(i), ld, 32'h0);
                add_row($sformatf("lbu a=%0d w=%0d", i, w), 1'b1, wb_pkg::WB_LBU, 5'(8 + i),
                        2'(i), ld, 32'h0);
            end
            ld = (w == 0) ? 32'h8001_7ffe : 32'h7ffe_8001;
            for (int i = 0; i < 4; i += 2) begin
                add_row($sformatf("lh a=%0d w=%0d", i, w), 1'b1, wb_pkg::WB_LH, 5'(12 + i),
                        2'(i), ld, 32'h0);
                add_row($sformatf("lhu a=%0d w=%0d", i, w), 1'b1, wb_pkg::WB_LHU, 5'(13 + i),
                        2'(i), ld, 32'h0);
            end
        end
        // partial word loads right behind their preload
        for (int i = 0; i < 4; i++) begin
            add_row("preload", 1'b1, wb_pkg::WB_ALU, 5'(16 + i), 2'd0, 32'h0, 32'h1122_3344);
            add_row($sformatf("lwl a=%0d", i), 1'b1, wb_pkg::WB_LWL, 5'(16 + i), 2'(i),
                    32'haabb_ccdd, 32'h0);
            add_row("preload", 1'b1, wb_pkg::WB_ALU, 5'(20 + i), 2'd0, 32'h0, 32'h5566_7788);
            add_row($sformatf("lwr a=%0d", i), 1'b1, wb_pkg::WB_LWR, 5'(20 + i), 2'(i),
                    32'h99ee_ff00, 32'h0);
        end
        // suppressed writes
        // idle cycles right behind a writing load to a real register
        add_row("idle r2", 1'b0, wb_pkg::WB_ALU, 5'd2, 2'd0, 32'h0, 32'hffff_ffff);
        add_row("idle r3", 1'b0, wb_pkg::WB_LW, 5'd3, 2'd0, 32'h0f0f_0f0f, 32'h0);
        add_row("alu r0", 1'b1, wb_pkg::WB_ALU, 5'd0, 2'd0, 32'h0, 32'hffff_ffff);
        add_row("lw r0", 1'b1, wb_pkg::WB_LW, 5'd0, 2'd0, 32'h5555_aaaa, 32'h0);
        add_row("none r1", 1'b1, wb_pkg::WB_NONE, 5'd1, 2'd0, 32'hffff_ffff, 32'hffff_ffff);
        // back to back on one register
        add_row("b2b alu r24", 1'b1, wb_pkg::WB_ALU, 5'd24, 2'd0, 32'h0, 32'hcafe_f00d);
        add_row("b2b lwr r24", 1'b1, wb_pkg::WB_LWR, 5'd24, 2'd1, 32'h0102_0304, 32'h0);
        add_row("b2b lwl r24", 1'b1, wb_pkg::WB_LWL, 5'd24, 2'd2, 32'ha0b0_c0d0, 32'h0);
        add_row("b2b lb r24", 1'b1, wb_pkg::WB_LB, 5'd24, 2'd3, 32'hf100_0000, 32'h0);
        // random load data as op cycles over LB to LWR
        for (int k = 0; k < 8; k++) begin
            op = wb_pkg::wb_op_t'(4'(2 + k % 7));
            ld = $random(seed);
            a  = 2'($random(seed));
            if (op == wb_pkg::WB_LH || op == wb_pkg::WB_LHU) a[0] = 1'b0;
            add_row($sformatf("random %0d", k), 1'b1, op, 5'(26 + k % 6), a, ld, 32'h0);
        end
    endtask

    // ------------------------------------------------------------------------
    // drive and check
    // ------------------------------------------------------------------------

    task automatic drive_row(input row_t r);
        mem_valid     = r.valid;
        mem_pc        = r.pc;
        mem_op        = r.op;
        mem_wnum      = r.wnum;
        mem_addr_lo   = r.addr_lo;
        mem_load_data = r.load_data;
        mem_alu_data  = r.alu_data;
    endtask

    // trace and register file two edges after the row was driven
    task automatic check_row(input row_t r);
        wb_pkg::word_t mask;
        mask = byte_mask(r.exp_wen);
        check_byte_en({r.name, " wen"}, r.exp_wen, debug_wb_rf_wen);
        check_word({r.name, " pc"}, r.exp_pc, debug_wb_pc);
        if (r.valid) begin
            check_reg_addr({r.name, " wnum"}, r.wnum, debug_wb_rf_wnum);
            check_word({r.name, " wdata"}, r.exp_wdata & mask, debug_wb_rf_wdata & mask);
        end
        check_word({r.name, " read"}, r.exp_reg, rs_data);
    endtask

    task automatic sweep_regs(input string name);
        for (int r = 0; r < 32; r++) begin
            rs_addr = 5'(r);
            rt_addr = 5'(31 - r);
            #1;
            check_word($sformatf("%s rs r%0d", name, r), model_regs[r], rs_data);
            check_word($sformatf("%s rt r%0d", name, 31 - r), model_regs[31 - r], rt_data);
        end
    endtask

    initial begin
        mem_valid     = 1'b0;
        mem_pc        = 32'h0;
        mem_op        = wb_pkg::WB_NONE;
        mem_wnum      = 5'd0;
        mem_addr_lo   = 2'd0;
        mem_load_data = 32'h0;
        mem_alu_data  = 32'h0;
        rs_addr       = 5'd0;
        rt_addr       = 5'd0;
        errors        = 0;
        seed          = 32'h6f67_587d;
        last_pc       = 32'h0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        build_table();
        // model back to the reset state for the first sweep
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        table_ready = 1'b1;

        @(posedge rst_n);
        sweep_regs("reset");
        check_byte_en("reset wen", 4'b0000, debug_wb_rf_wen);

        // two rows in flight so row i is checked while row i+2 is driven
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(posedge clk);
            #1;
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                mem_valid = 1'b0;
            end
            if (i >= 2) begin
                rs_addr = rows[i-2].wnum;
                #2;
                check_row(rows[i-2]);
            end
        end

        // final register contents
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].exp_wen != 4'b0000) model_regs[rows[i].wnum] = rows[i].exp_reg;
        end
        @(posedge clk);
        #1;
        sweep_regs("final");

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog over the table length plus slack for reset and the register sweeps
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * 20);
        $display("timeout: the run did not finish within %0d clock cycles", rows.size() + 20);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- sim.f
logic/wb_pkg.sv
logic/wb_byte_lane.sv
logic/wb_stage_reg.sv
logic/wb_result_merge.sv
logic/reg_file.sv
logic/wb_top.sv
bench/wb_clock_gen.sv
bench/wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module wb_tb -f sim.f -o wb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/wb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST FAILED ***" sim.log; then
    exit 1
fi
exit 0
